// File: common/bridge_pkg.sv
// bridge package
// shared bus widths and the AHB-Lite field encodings used by
// the bridges, the arbiter and the SRAM slave
package bridge_pkg;

    // default widths, one word each
    parameter int ADDR_WIDTH = 32;
    parameter int DATA_WIDTH = 32;

    // htrans codes, only idle and nonsequential are ever driven
    parameter logic [1:0] HTRANS_IDLE   = 2'b00;
    parameter logic [1:0] HTRANS_NONSEQ = 2'b10;

    // single transfers only
    parameter logic [2:0] HBURST_SINGLE = 3'b000;

    // non-cacheable, non-bufferable, privileged data access
    parameter logic [3:0] HPROT_DATA_PRIV = 4'b0011;

    // hsize codes
    parameter logic [2:0] HSIZE_BYTE = 3'b000;
    parameter logic [2:0] HSIZE_HALF = 3'b001;
    parameter logic [2:0] HSIZE_WORD = 3'b010;

    // hresp codes
    parameter logic HRESP_OKAY  = 1'b0;
    parameter logic HRESP_ERROR = 1'b1;

endpackage

// File: common/ahb_if.sv
// AHB-Lite interface
// one master/slave link, with a bus request line for arbitration
interface ahb_if #(
    parameter int ADDR_WIDTH = bridge_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = bridge_pkg::DATA_WIDTH
);

    // master to slave
    logic                  hbusreq;
    logic                  hsel;
    logic [ADDR_WIDTH-1:0] haddr;
    logic                  hwrite;
    logic [2:0]            hsize;
    logic [2:0]            hburst;
    logic [3:0]            hprot;
    logic [1:0]            htrans;
    logic                  hmastlock;
    logic [DATA_WIDTH-1:0] hwdata;
    logic                  hready;

    // slave to master
    logic                  hreadyout;
    logic [DATA_WIDTH-1:0] hrdata;
    logic                  hresp;

    modport master (
        output hbusreq, hsel, haddr, hwrite, hsize, hburst, hprot, htrans,
        output hmastlock, hwdata, hready,
        input  hreadyout, hrdata, hresp
    );

    modport slave (
        input  hbusreq, hsel, haddr, hwrite, hsize, hburst, hprot, htrans,
        input  hmastlock, hwdata, hready,
        output hreadyout, hrdata, hresp
    );

endinterface

// File: apb_to_ahb/apb_to_ahb.sv
// APB to AHB-Lite bridge
// maps each APB transfer onto one AHB single transfer and
// returns the AHB completion as a registered pready/pslverr
module apb_to_ahb #(
    parameter int ADDR_WIDTH = bridge_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = bridge_pkg::DATA_WIDTH
) (
    input  logic                  pclk,
    input  logic                  presetn,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [ADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0] pwdata,
    output logic [DATA_WIDTH-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    ahb_if.master                 ahb
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_DATA = 2'b01,
        ST_TERM = 2'b11
    } state_t;

    state_t                state;
    state_t                state_nxt;
    logic                  pready_nxt;
    logic                  pslverr_nxt;
    logic                  addr_phase;
    logic [DATA_WIDTH-1:0] hrdata_q;

    // address phase only from idle, and only once the bus is ours
    assign addr_phase = psel & ahb.hreadyout & (state == ST_IDLE);

    always_comb begin
        state_nxt   = state;
        pready_nxt  = 1'b0;
        pslverr_nxt = 1'b0;
        case (state)
            ST_IDLE: begin
                if (addr_phase) begin
                    state_nxt = ST_DATA;
                end
            end
            ST_DATA: begin
                // error completes on its first cycle, hreadyout still low
                if (penable & (ahb.hreadyout | ahb.hresp)) begin
                    state_nxt   = ST_TERM;
                    pready_nxt  = 1'b1;
                    pslverr_nxt = ahb.hresp;
                end
            end
            ST_TERM: begin
                // wait for the APB master to leave the access phase
                if (!penable) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state   <= ST_IDLE;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            // deselect drops straight back to idle
            state   <= psel ? state_nxt : ST_IDLE;
            pready  <= pready_nxt;
            pslverr <= pslverr_nxt;
        end
    end

    // one register so read data lines up with pready
    always_ff @(posedge pclk) begin
        hrdata_q <= ahb.hrdata;
    end
    assign prdata = hrdata_q;

    // request the bus until the address phase has gone out
    assign ahb.hbusreq   = psel & (state == ST_IDLE);
    assign ahb.hsel      = addr_phase;
    assign ahb.htrans    = addr_phase ? bridge_pkg::HTRANS_NONSEQ : bridge_pkg::HTRANS_IDLE;
    assign ahb.hwrite    = addr_phase & pwrite;
    assign ahb.haddr     = paddr;
    assign ahb.hwdata    = pwdata;
    assign ahb.hburst    = bridge_pkg::HBURST_SINGLE;
    assign ahb.hprot     = bridge_pkg::HPROT_DATA_PRIV;
    assign ahb.hmastlock = 1'b0;
    assign ahb.hready    = ahb.hreadyout;

    // transfer size follows the data width
    generate
        if (DATA_WIDTH <= 8) begin : g_size_byte
            assign ahb.hsize = bridge_pkg::HSIZE_BYTE;
        end else if (DATA_WIDTH <= 16) begin : g_size_half
            assign ahb.hsize = bridge_pkg::HSIZE_HALF;
        end else begin : g_size_word
            assign ahb.hsize = bridge_pkg::HSIZE_WORD;
        end
    endgenerate

endmodule

// File: source/ahb_arbiter.sv
// AHB-Lite round-robin arbiter
// two bridge masters share one slave, the grant is held
// through the owner's data phase
module ahb_arbiter (
    input  logic  pclk,
    input  logic  presetn,
    ahb_if.slave  m_a,
    ahb_if.slave  m_b,
    ahb_if.master s
);

    logic gnt_a;
    logic gnt_b;
    logic gnt_a_nxt;
    logic gnt_b_nxt;
    logic last_b;
    logic owner_dphase;
    logic owner_req;
    logic addr_taken;
    logic done;
    logic free;

    // slave accepted an address from the owner
    assign addr_taken = s.hsel & s.hready & (s.htrans == bridge_pkg::HTRANS_NONSEQ);
    // owner's data phase ends, ok or second error cycle
    assign done       = owner_dphase & s.hreadyout;
    assign owner_req  = gnt_b ? m_b.hbusreq : m_a.hbusreq;
    // no grant, finished transfer, or owner gave up before its address phase
    assign free       = ~(gnt_a | gnt_b) | done | (~owner_dphase & ~owner_req);

    always_comb begin
        gnt_a_nxt = gnt_a;
        gnt_b_nxt = gnt_b;
        if (free) begin
            if (m_a.hbusreq & m_b.hbusreq) begin
                // both want it, the one that lost last time wins
                gnt_a_nxt = last_b;
                gnt_b_nxt = ~last_b;
            end else begin
                gnt_a_nxt = m_a.hbusreq;
                gnt_b_nxt = m_b.hbusreq;
            end
        end
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            gnt_a        <= 1'b0;
            gnt_b        <= 1'b0;
            // a goes first after reset
            last_b       <= 1'b1;
            owner_dphase <= 1'b0;
        end else begin
            gnt_a <= gnt_a_nxt;
            gnt_b <= gnt_b_nxt;
            if (free & (gnt_a_nxt | gnt_b_nxt)) begin
                last_b <= gnt_b_nxt;
            end
            if (addr_taken) begin
                owner_dphase <= 1'b1;
            end else if (done) begin
                owner_dphase <= 1'b0;
            end
        end
    end

    // granted master onto the slave side
    assign s.hbusreq   = m_a.hbusreq | m_b.hbusreq;
    assign s.hsel      = (gnt_a & m_a.hsel) | (gnt_b & m_b.hsel);
    assign s.htrans    = gnt_b ? m_b.htrans : (gnt_a ? m_a.htrans : bridge_pkg::HTRANS_IDLE);
    assign s.haddr     = gnt_b ? m_b.haddr : m_a.haddr;
    assign s.hwrite    = gnt_b ? m_b.hwrite : m_a.hwrite;
    assign s.hsize     = gnt_b ? m_b.hsize : m_a.hsize;
    assign s.hburst    = gnt_b ? m_b.hburst : m_a.hburst;
    assign s.hprot     = gnt_b ? m_b.hprot : m_a.hprot;
    assign s.hmastlock = gnt_b ? m_b.hmastlock : m_a.hmastlock;
    assign s.hwdata    = gnt_b ? m_b.hwdata : m_a.hwdata;
    // single slave, its own ready drives the bus
    assign s.hready    = s.hreadyout;

    // responses back, ready only to the owner
    assign m_a.hreadyout = gnt_a & s.hreadyout;
    assign m_b.hreadyout = gnt_b & s.hreadyout;
    assign m_a.hrdata    = s.hrdata;
    assign m_b.hrdata    = s.hrdata;
    assign m_a.hresp     = s.hresp;
    assign m_b.hresp     = s.hresp;

endmodule

// File: source/ahb_sram.sv
// AHB-Lite SRAM slave
// word-addressed memory with a fixed number of wait states and
// the two-cycle error response past the end of the array
module ahb_sram #(
    parameter int ADDR_WIDTH  = bridge_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH  = bridge_pkg::DATA_WIDTH,
    parameter int MEM_DEPTH   = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic pclk,
    input  logic presetn,
    ahb_if.slave ahb
);

    localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CNT_W = $clog2(WAIT_STATES + 2);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic                  dphase;
    logic                  err_1st;
    logic                  err_2nd;
    logic [CNT_W-1:0]      wait_cnt;
    logic [IDX_W-1:0]      d_idx;
    logic                  d_write;
    logic                  accept;
    logic                  in_range;
    logic                  finish;

    assign accept   = ahb.hsel & ahb.hready & (ahb.htrans == bridge_pkg::HTRANS_NONSEQ);
    // haddr is a word index
    assign in_range = ahb.haddr < ADDR_WIDTH'(MEM_DEPTH);
    assign finish   = dphase & (wait_cnt == '0);

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            dphase   <= 1'b0;
            err_1st  <= 1'b0;
            err_2nd  <= 1'b0;
            wait_cnt <= '0;
            d_idx    <= '0;
            d_write  <= 1'b0;
        end else begin
            // error runs two cycles
            err_2nd <= err_1st;
            err_1st <= 1'b0;
            if (finish) begin
                dphase <= 1'b0;
            end else if (dphase) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (accept) begin
                d_write <= ahb.hwrite;
                if (in_range) begin
                    dphase   <= 1'b1;
                    wait_cnt <= CNT_W'(WAIT_STATES);
                    d_idx    <= ahb.haddr[IDX_W-1:0];
                end else begin
                    err_1st <= 1'b1;
                end
            end
        end
    end

    // array cleared at reset, written at the end of a write data phase
    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (finish & d_write) begin
            mem[d_idx] <= ahb.hwdata;
        end
    end

    // low while counting and in the first error cycle
    assign ahb.hreadyout = ~(err_1st | (dphase & (wait_cnt != '0)));
    assign ahb.hresp     = (err_1st | err_2nd) ? bridge_pkg::HRESP_ERROR : bridge_pkg::HRESP_OKAY;
    assign ahb.hrdata    = mem[d_idx];

endmodule

// File: source/dual_apb_ahb_top.sv
// dual APB register-access subsystem
// two APB ports, each through its own bridge, share one SRAM
// over a round-robin arbitrated AHB-Lite bus
module dual_apb_ahb_top #(
    parameter int ADDR_WIDTH  = bridge_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH  = bridge_pkg::DATA_WIDTH,
    parameter int MEM_DEPTH   = 64,
    parameter int WAIT_STATES = 1
) (
    input  logic                  pclk,
    input  logic                  presetn,
    // port a
    input  logic                  a_psel,
    input  logic                  a_penable,
    input  logic                  a_pwrite,
    input  logic [ADDR_WIDTH-1:0] a_paddr,
    input  logic [DATA_WIDTH-1:0] a_pwdata,
    output logic [DATA_WIDTH-1:0] a_prdata,
    output logic                  a_pready,
    output logic                  a_pslverr,
    // port b
    input  logic                  b_psel,
    input  logic                  b_penable,
    input  logic                  b_pwrite,
    input  logic [ADDR_WIDTH-1:0] b_paddr,
    input  logic [DATA_WIDTH-1:0] b_pwdata,
    output logic [DATA_WIDTH-1:0] b_prdata,
    output logic                  b_pready,
    output logic                  b_pslverr
);

    // bridge links and the shared slave bus
    ahb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) m_a ();
    ahb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) m_b ();
    ahb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) s_bus ();

    apb_to_ahb #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_bridge_a (
        .pclk(pclk), .presetn(presetn),
        .psel(a_psel), .penable(a_penable), .pwrite(a_pwrite),
        .paddr(a_paddr), .pwdata(a_pwdata),
        .prdata(a_prdata), .pready(a_pready), .pslverr(a_pslverr),
        .ahb(m_a)
    );

    apb_to_ahb #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_bridge_b (
        .pclk(pclk), .presetn(presetn),
        .psel(b_psel), .penable(b_penable), .pwrite(b_pwrite),
        .paddr(b_paddr), .pwdata(b_pwdata),
        .prdata(b_prdata), .pready(b_pready), .pslverr(b_pslverr),
        .ahb(m_b)
    );

    ahb_arbiter u_arbiter (
        .pclk(pclk), .presetn(presetn),
        .m_a(m_a), .m_b(m_b), .s(s_bus)
    );

    ahb_sram #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH),
        .MEM_DEPTH(MEM_DEPTH), .WAIT_STATES(WAIT_STATES)
    ) u_sram (
        .pclk(pclk), .presetn(presetn), .ahb(s_bus)
    );

endmodule

// File: tb/bridge_checker.sv
// bus protocol checker
// concurrent assertions bound into each bridge and into the arbiter
module bridge_checker #(
    parameter bit ARB_SIDE = 1'b0
) (
    input logic pclk,
    input logic presetn,
    input logic pready,
    input logic pslverr,
    input logic hsel,
    input logic hreadyout,
    input logic req_a,
    input logic req_b,
    input logic rdy_a,
    input logic rdy_b
);

    // address phase only on a ready bus
    a_sel_ready: assert property (@(posedge pclk) disable iff (!presetn) hsel |-> hreadyout)
        else $error("hsel asserted while hreadyout was low");

    generate
        if (ARB_SIDE) begin : g_arb
            // only the owner may see ready
            a_one_ready: assert property (@(posedge pclk) disable iff (!presetn)
                !(req_a && req_b && rdy_a && rdy_b))
                else $error("both masters saw hreadyout high while both requested");
        end else begin : g_bridge
            a_pready_pulse: assert property (@(posedge pclk) disable iff (!presetn)
                pready |=> !pready)
                else $error("pready stayed high for more than one cycle");
            a_err_with_ready: assert property (@(posedge pclk) disable iff (!presetn)
                pslverr |-> pready)
                else $error("pslverr high without pready");
        end
    endgenerate

endmodule

bind apb_to_ahb bridge_checker #(.ARB_SIDE(1'b0)) u_bridge_chk (
    .pclk(pclk), .presetn(presetn), .pready(pready), .pslverr(pslverr),
    .hsel(ahb.hsel), .hreadyout(ahb.hreadyout),
    .req_a(1'b0), .req_b(1'b0), .rdy_a(1'b0), .rdy_b(1'b0)
);

bind ahb_arbiter bridge_checker #(.ARB_SIDE(1'b1)) u_arb_chk (
    .pclk(pclk), .presetn(presetn), .pready(1'b0), .pslverr(1'b0),
    .hsel(s.hsel), .hreadyout(s.hreadyout),
    .req_a(m_a.hbusreq), .req_b(m_b.hbusreq),
    .rdy_a(m_a.hreadyout), .rdy_b(m_b.hreadyout)
);

// File: tb/tb_top.sv
// testbench for the dual APB subsystem
// replays the transfer file on both APB ports at once and checks
// read data and pslverr at every pready
module tb_top;

    localparam int          CLK_HALF        = 5;
    localparam int          RESET_CYCLES    = 16;
    localparam int          MEM_DEPTH       = 64;
    localparam int          WAIT_STATES     = 2;
    localparam int          MAX_LINES       = 64;
    localparam int          COLS            = 6;
    localparam int          CYCLES_PER_XFER = 40;
    localparam int unsigned SEED            = 32'h3c75;
    localparam string       STIM_FILE       = "tb/stimulus_input.txt";
    localparam logic [31:0] NO_LINE         = 32'hffffffff;

    // column order of one file line
    localparam int COL_PORT  = 0;
    localparam int COL_WRITE = 1;
    localparam int COL_ADDR  = 2;
    localparam int COL_WDATA = 3;
    localparam int COL_RDATA = 4;
    localparam int COL_ERR   = 5;

    logic        pclk;
    logic        presetn;
    // index 0 is port a, index 1 is port b
    logic [1:0]  psel;
    logic [1:0]  penable;
    logic [1:0]  pwrite;
    logic [31:0] paddr  [2];
    logic [31:0] pwdata [2];
    logic [31:0] prdata [2];
    logic [1:0]  pready;
    logic [1:0]  pslverr;

    logic [31:0] stim [COLS*MAX_LINES];
    bit          done_flag [MAX_LINES];
    int          n_lines;
    int          errors;
    int          checks;

    dual_apb_ahb_top #(.MEM_DEPTH(MEM_DEPTH), .WAIT_STATES(WAIT_STATES)) DUT (
        .pclk(pclk), .presetn(presetn),
        .a_psel(psel[0]), .a_penable(penable[0]), .a_pwrite(pwrite[0]),
        .a_paddr(paddr[0]), .a_pwdata(pwdata[0]),
        .a_prdata(prdata[0]), .a_pready(pready[0]), .a_pslverr(pslverr[0]),
        .b_psel(psel[1]), .b_penable(penable[1]), .b_pwrite(pwrite[1]),
        .b_paddr(paddr[1]), .b_pwdata(pwdata[1]),
        .b_prdata(prdata[1]), .b_pready(pready[1]), .b_pslverr(pslverr[1])
    );

    always #CLK_HALF pclk = ~pclk;

    // one unit past the rising edge, where inputs change and outputs are stable
    task automatic tick();
        @(posedge pclk);
        #1;
    endtask

    function automatic logic [31:0] field(input int line, input int col);
        return stim[line*COLS + col];
    endfunction

    // wait for earlier same-address lines of the other port
    function automatic bit conflicts_cleared(input int line);
        for (int j = 0; j < line; j++) begin
            if (field(j, COL_PORT) != field(line, COL_PORT) &&
                field(j, COL_ADDR) == field(line, COL_ADDR) && !done_flag[j]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic apb_transfer(input int port, input int line);
        int          idle;
        string       name;
        logic        is_write;
        logic        exp_err;
        logic [31:0] exp_data;
        is_write = field(line, COL_WRITE) != 0;
        exp_err  = field(line, COL_ERR) != 0;
        exp_data = field(line, COL_RDATA);
        name     = $sformatf("line %0d port %s %s 0x%08h", line, port ? "b" : "a",
                             is_write ? "write" : "read", field(line, COL_ADDR));
        idle     = $urandom_range(3, 0);
        repeat (idle) tick();
        // setup phase
        psel[port]    = 1'b1;
        penable[port] = 1'b0;
        pwrite[port]  = is_write;
        paddr[port]   = field(line, COL_ADDR);
        pwdata[port]  = is_write ? field(line, COL_WDATA) : 32'h0;
        tick();
        // access phase, held until pready
        penable[port] = 1'b1;
        tick();
        while (!pready[port]) tick();
        checks++;
        assert (pslverr[port] == exp_err) else begin
            errors++;
            $display("CHECK FAILED %s: pslverr expected %0b, actual %0b",
                     name, exp_err, pslverr[port]);
        end
        // no read data behind an error response
        if (!is_write && !exp_err) begin
            checks++;
            assert (prdata[port] == exp_data) else begin
                errors++;
                $display("CHECK FAILED %s: prdata expected 0x%08h, actual 0x%08h",
                         name, exp_data, prdata[port]);
            end
        end
        psel[port]      = 1'b0;
        penable[port]   = 1'b0;
        done_flag[line] = 1'b1;
        tick();
    endtask

    task automatic run_port(input int port);
        for (int i = 0; i < n_lines; i++) begin
            if (int'(field(i, COL_PORT)) == port) begin
                while (!conflicts_cleared(i)) tick();
                apb_transfer(port, i);
            end
        end
    endtask

    initial begin
        pclk       = 1'b0;
        presetn    = 1'b0;
        psel       = '0;
        penable    = '0;
        pwrite     = '0;
        paddr[0]   = '0;
        paddr[1]   = '0;
        pwdata[0]  = '0;
        pwdata[1]  = '0;
        errors     = 0;
        checks     = 0;
        n_lines    = 0;
        void'($urandom(SEED));
        // sentinel marks the end of the loaded lines
        for (int k = 0; k < COLS*MAX_LINES; k++) begin
            stim[k] = NO_LINE;
        end
        $readmemh(STIM_FILE, stim);
        while (n_lines < MAX_LINES && field(n_lines, COL_PORT) != NO_LINE) begin
            done_flag[n_lines] = 1'b0;
            n_lines++;
        end
        repeat (RESET_CYCLES) @(posedge pclk);
        #1;
        presetn = 1'b1;
        tick();
        // both ports quiet before any psel
        checks++;
        assert (pready == 2'b00 && pslverr == 2'b00) else begin
            errors++;
            $display("CHECK FAILED after reset: pready/pslverr expected 00/00, actual %b/%b",
                     pready, pslverr);
        end
        fork
            run_port(0);
            run_port(1);
        join
        $display("%0d errors in %0d checks over %0d transfers", errors, checks, n_lines);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog, limit scales with the number of transfers
    initial begin
        @(posedge presetn);
        repeat (n_lines * CYCLES_PER_XFER) @(posedge pclk);
        $display("watchdog expired after %0d cycles, a port never finished its transfers",
                 n_lines * CYCLES_PER_XFER);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb/stimulus_input.txt
// port (0 = a, 1 = b), write (1) or read (0), word address, write data,
// expected read data, expected pslverr
0 1 00000003 a5a50001 00000000 0
0 0 00000003 00000000 a5a50001 0
// past the end, aliases word 5 in its low bits
0 1 00000045 deadbeef 00000000 1
0 0 00000005 00000000 00000000 0
0 0 00000100 00000000 00000000 1
// written on one port, read on the other
1 1 00000010 cafe0010 00000000 0
0 0 00000010 00000000 cafe0010 0
0 1 00000020 12345678 00000000 0
1 0 00000020 00000000 12345678 0
// overlapping traffic on both ports
0 1 00000001 11110001 00000000 0
1 1 00000002 22220002 00000000 0
0 1 00000004 11110004 00000000 0
1 1 00000006 22220006 00000000 0
0 0 00000002 00000000 22220002 0
1 0 00000001 00000000 11110001 0
1 1 00000003 33330003 00000000 0
0 0 00000003 00000000 33330003 0
1 0 00000004 00000000 11110004 0
0 0 00000006 00000000 22220006 0
// last word, then the first word out of range
1 1 0000003f ffff003f 00000000 0
1 0 0000003f 00000000 ffff003f 0
1 1 00000040 55555555 00000000 1
0 0 00000040 00000000 00000000 1
1 0 00000005 00000000 00000000 0

// File: verilog.f
common/bridge_pkg.sv
common/ahb_if.sv
apb_to_ahb/apb_to_ahb.sv
source/ahb_arbiter.sv
source/ahb_sram.sv
source/dual_apb_ahb_top.sv
tb/bridge_checker.sv
tb/tb_top.sv

// File: Makefile
SIM = obj_dir/Vtb_top

all: run

$(SIM): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module tb_top -f verilog.f -o Vtb_top

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
